//--- hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:2] pc_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [5:0]  instr_kind_t;
    typedef logic [4:0]  alu_ctrl_t;
    typedef logic [1:0]  res_src_t;

    // kinds are grouped so each class is one contiguous range
    localparam instr_kind_t KIND_INVALID = 6'd0;
    localparam instr_kind_t
        KIND_LB    = 6'd1,  KIND_LH    = 6'd2,  KIND_LW    = 6'd3,
        KIND_LBU   = 6'd4,  KIND_LHU   = 6'd5;
    localparam instr_kind_t
        KIND_SB    = 6'd6,  KIND_SH    = 6'd7,  KIND_SW    = 6'd8;
    localparam instr_kind_t
        KIND_ADDI  = 6'd9,  KIND_SLLI  = 6'd10, KIND_SLTI  = 6'd11,
        KIND_SLTIU = 6'd12, KIND_XORI  = 6'd13, KIND_SRLI  = 6'd14,
        KIND_SRAI  = 6'd15, KIND_ORI   = 6'd16, KIND_ANDI  = 6'd17;
    localparam instr_kind_t
        KIND_ADD   = 6'd18, KIND_SUB   = 6'd19, KIND_SLL   = 6'd20,
        KIND_SLT   = 6'd21, KIND_SLTU  = 6'd22, KIND_XOR   = 6'd23,
        KIND_SRL   = 6'd24, KIND_SRA   = 6'd25, KIND_OR    = 6'd26,
        KIND_AND   = 6'd27;
    localparam instr_kind_t
        KIND_LUI   = 6'd28, KIND_AUIPC = 6'd29;
    localparam instr_kind_t
        KIND_BEQ   = 6'd30, KIND_BNE   = 6'd31, KIND_BLT   = 6'd32,
        KIND_BGE   = 6'd33, KIND_BLTU  = 6'd34, KIND_BGEU  = 6'd35;
    localparam instr_kind_t
        KIND_JAL   = 6'd36, KIND_JALR  = 6'd37,
        KIND_FENCE = 6'd38, KIND_FENCE_I = 6'd39;

    // opcode bits 6:2
    localparam logic [4:0] OPG_LOAD     = 5'b00000;
    localparam logic [4:0] OPG_MISC_MEM = 5'b00011;
    localparam logic [4:0] OPG_OP_IMM   = 5'b00100;
    localparam logic [4:0] OPG_AUIPC    = 5'b00101;
    localparam logic [4:0] OPG_STORE    = 5'b01000;
    localparam logic [4:0] OPG_OP       = 5'b01100;
    localparam logic [4:0] OPG_LUI      = 5'b01101;
    localparam logic [4:0] OPG_BRANCH   = 5'b11000;
    localparam logic [4:0] OPG_JALR     = 5'b11001;
    localparam logic [4:0] OPG_JAL      = 5'b11011;

    localparam logic [3:0] ALU_ADD      = 4'd0;
    localparam logic [3:0] ALU_SUB      = 4'd1;
    localparam logic [3:0] ALU_XOR      = 4'd2;
    localparam logic [3:0] ALU_OR       = 4'd3;
    localparam logic [3:0] ALU_AND      = 4'd4;
    localparam logic [3:0] ALU_SHL      = 4'd5;
    localparam logic [3:0] ALU_SHR      = 4'd6;
    localparam logic [3:0] ALU_CMP_EQ   = 4'd8;
    localparam logic [3:0] ALU_CMP_NEQ  = 4'd9;
    localparam logic [3:0] ALU_CMP_LTS  = 4'd10;
    localparam logic [3:0] ALU_CMP_LTU  = 4'd11;
    localparam logic [3:0] ALU_CMP_NLTS = 4'd12;
    localparam logic [3:0] ALU_CMP_NLTU = 4'd13;

    localparam logic OP1_REG = 1'b0;
    localparam logic OP1_PC  = 1'b1;
    localparam logic OP2_REG = 1'b0;
    localparam logic OP2_IMM = 1'b1;

    localparam res_src_t RES_ALU    = 2'd0;
    localparam res_src_t RES_MEMORY = 2'd1;
    localparam res_src_t RES_PC_P4  = 2'd2;

endpackage

//--- hdl/rv_decode_slot.sv
`timescale 1ns/1ps

module rv_decode_slot
    import rv_decode_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_stall,
    input  logic  i_flush,
    input  word_t i_data,
    input  pc_t   i_pc,
    input  pc_t   i_pc_p4,
    output word_t o_instr,
    output pc_t   o_pc,
    output pc_t   o_pc_p4,
    output logic  o_slot_empty
);

    pc_t  pc_q;
    pc_t  pc_p4_q;
    logic flush_d;

    // reset, then flush, then stall
    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            pc_q    <= '0;
            pc_p4_q <= '0;
        end
        else if (!i_stall)
        begin
            pc_q    <= i_pc;
            pc_p4_q <= i_pc_p4;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            flush_d <= 1'b0;
        else
            flush_d <= i_flush;
    end

    // word arrives a cycle after its pc, so the flushed one shows up next cycle
    assign o_instr      = (i_reset || flush_d) ? '0 : i_data;
    assign o_slot_empty = i_reset | i_flush | flush_d;
    assign o_pc         = pc_q;
    assign o_pc_p4      = pc_p4_q;

endmodule

//--- hdl/rv_instr_classify.sv
`timescale 1ns/1ps

module rv_instr_classify
    import rv_decode_pkg::*;
(
    input  word_t       i_instr,
    output instr_kind_t o_kind,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output funct3_t     o_funct3
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [4:0]  opg;
    funct3_t     funct3;
    logic [6:0]  funct7;
    logic        full;
    instr_kind_t kind;

    assign opg    = i_instr[6:2];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    // compressed encodings are not supported
    assign full   = (i_instr[1:0] == 2'b11);

    always_comb
    begin
        kind = KIND_INVALID;
        if (full)
        begin
            case (opg)
                OPG_LOAD:
                    case (funct3)
                        3'b000: kind = KIND_LB;
                        3'b001: kind = KIND_LH;
                        3'b010: kind = KIND_LW;
                        3'b100: kind = KIND_LBU;
                        3'b101: kind = KIND_LHU;
                        default: kind = KIND_INVALID;
                    endcase
                OPG_STORE:
                    case (funct3)
                        3'b000: kind = KIND_SB;
                        3'b001: kind = KIND_SH;
                        3'b010: kind = KIND_SW;
                        default: kind = KIND_INVALID;
                    endcase
                OPG_OP_IMM:
                    case (funct3)
                        3'b000: kind = KIND_ADDI;
                        3'b001: kind = (funct7 == F7_BASE) ? KIND_SLLI : KIND_INVALID;
                        3'b010: kind = KIND_SLTI;
                        3'b011: kind = KIND_SLTIU;
                        3'b100: kind = KIND_XORI;
                        3'b101: kind = (funct7 == F7_BASE) ? KIND_SRLI :
                                       (funct7 == F7_ALT)  ? KIND_SRAI : KIND_INVALID;
                        3'b110: kind = KIND_ORI;
                        default: kind = KIND_ANDI;
                    endcase
                OPG_OP:
                    case ({funct7, funct3})
                        {F7_BASE, 3'b000}: kind = KIND_ADD;
                        {F7_ALT,  3'b000}: kind = KIND_SUB;
                        {F7_BASE, 3'b001}: kind = KIND_SLL;
                        {F7_BASE, 3'b010}: kind = KIND_SLT;
                        {F7_BASE, 3'b011}: kind = KIND_SLTU;
                        {F7_BASE, 3'b100}: kind = KIND_XOR;
                        {F7_BASE, 3'b101}: kind = KIND_SRL;
                        {F7_ALT,  3'b101}: kind = KIND_SRA;
                        {F7_BASE, 3'b110}: kind = KIND_OR;
                        {F7_BASE, 3'b111}: kind = KIND_AND;
                        default: kind = KIND_INVALID;
                    endcase
                OPG_BRANCH:
                    case (funct3)
                        3'b000: kind = KIND_BEQ;
                        3'b001: kind = KIND_BNE;
                        3'b100: kind = KIND_BLT;
                        3'b101: kind = KIND_BGE;
                        3'b110: kind = KIND_BLTU;
                        3'b111: kind = KIND_BGEU;
                        default: kind = KIND_INVALID;
                    endcase
                OPG_MISC_MEM:
                    case (funct3)
                        3'b000: kind = KIND_FENCE;
                        3'b001: kind = KIND_FENCE_I;
                        default: kind = KIND_INVALID;
                    endcase
                OPG_JALR: kind = (funct3 == 3'b000) ? KIND_JALR : KIND_INVALID;
                OPG_JAL: kind = KIND_JAL;
                OPG_LUI: kind = KIND_LUI;
                OPG_AUIPC: kind = KIND_AUIPC;
                default: kind = KIND_INVALID;
            endcase
        end
    end

    // lui has no rs1 field so hazard logic sees x0
    assign o_rs1    = (kind == KIND_LUI) ? '0 : i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_funct3 = funct3;
    assign o_kind   = kind;

endmodule

//--- hdl/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
    import rv_decode_pkg::*;
(
    input  word_t       i_instr,
    input  instr_kind_t i_kind,
    output word_t       o_imm
);

    logic sign;

    assign sign = i_instr[31];

    always_comb
    begin
        if (i_kind == KIND_JAL)
            o_imm = {{12{sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
        else if (i_kind inside {KIND_LUI, KIND_AUIPC})
            o_imm = {i_instr[31:12], 12'b0};
        else if (i_kind inside {KIND_JALR, [KIND_LB:KIND_LHU], [KIND_ADDI:KIND_ANDI]})
            o_imm = {{20{sign}}, i_instr[31:20]};
        else if (i_kind inside {[KIND_BEQ:KIND_BGEU]})
            o_imm = {{20{sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
        else if (i_kind inside {[KIND_SB:KIND_SW]})
            o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
        else
            o_imm = '0;
    end

endmodule

//--- hdl/rv_ctrl_gen.sv
`timescale 1ns/1ps

module rv_ctrl_gen
    import rv_decode_pkg::*;
(
    input  instr_kind_t i_kind,
    input  logic        i_slot_empty,
    output logic        o_reg_write,
    output logic        o_mem_read,
    output logic        o_mem_write,
    output logic        o_jump,
    output logic        o_branch,
    output logic        o_pc_sel,
    output logic        o_alu_op1_sel,
    output logic        o_alu_op2_sel,
    output logic        o_inv_instr,
    output res_src_t    o_res_src,
    output alu_ctrl_t   o_alu_ctrl
);

    logic       is_load;
    logic       is_store;
    logic       is_op_imm;
    logic       is_op_reg;
    logic       is_branch;
    logic       is_jump;
    logic       shift_arith;
    logic [3:0] alu_op;

    assign is_load   = i_kind inside {[KIND_LB:KIND_LHU]};
    assign is_store  = i_kind inside {[KIND_SB:KIND_SW]};
    assign is_op_imm = i_kind inside {[KIND_ADDI:KIND_ANDI]};
    assign is_op_reg = i_kind inside {[KIND_ADD:KIND_AND]};
    assign is_branch = i_kind inside {[KIND_BEQ:KIND_BGEU]};
    assign is_jump   = i_kind inside {KIND_JAL, KIND_JALR};

    assign o_reg_write = is_load | is_op_imm | is_op_reg | is_jump |
                         (i_kind == KIND_LUI) | (i_kind == KIND_AUIPC);
    assign o_mem_read  = is_load;
    assign o_mem_write = is_store;
    assign o_jump      = is_jump;
    assign o_branch    = is_branch;
    assign o_pc_sel    = (i_kind == KIND_JALR);

    assign o_alu_op1_sel = (i_kind inside {KIND_AUIPC, KIND_JAL}) ? OP1_PC : OP1_REG;
    assign o_alu_op2_sel = (is_op_reg || is_branch) ? OP2_REG : OP2_IMM;

    assign o_res_src = is_load ? RES_MEMORY :
                       is_jump ? RES_PC_P4  : RES_ALU;

    // branches reuse the compare ops of slt/sltu
    always_comb
    begin
        case (i_kind)
            KIND_BEQ: alu_op = ALU_CMP_EQ;
            KIND_BNE: alu_op = ALU_CMP_NEQ;
            KIND_SLTI, KIND_SLT, KIND_BLT: alu_op = ALU_CMP_LTS;
            KIND_SLTIU, KIND_SLTU, KIND_BLTU: alu_op = ALU_CMP_LTU;
            KIND_BGE: alu_op = ALU_CMP_NLTS;
            KIND_BGEU: alu_op = ALU_CMP_NLTU;
            KIND_SUB: alu_op = ALU_SUB;
            KIND_XORI, KIND_XOR: alu_op = ALU_XOR;
            KIND_ORI, KIND_OR: alu_op = ALU_OR;
            KIND_ANDI, KIND_AND: alu_op = ALU_AND;
            KIND_SLLI, KIND_SLL: alu_op = ALU_SHL;
            KIND_SRLI, KIND_SRAI, KIND_SRL, KIND_SRA: alu_op = ALU_SHR;
            default: alu_op = ALU_ADD;
        endcase
    end

    assign shift_arith = (i_kind == KIND_SRAI) || (i_kind == KIND_SRA);
    assign o_alu_ctrl  = {shift_arith, alu_op};

    // no flag for bubbles
    assign o_inv_instr = (i_kind == KIND_INVALID) && !i_slot_empty;

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode
    import rv_decode_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_stall,
    input  logic        i_flush,
    input  word_t       i_data,
    input  pc_t         i_pc,
    input  pc_t         i_pc_p4,
    output reg_idx_t    o_rs1,
    output reg_idx_t    o_rs2,
    output reg_idx_t    o_rd,
    output pc_t         o_pc,
    output pc_t         o_pc_p4,
    output word_t       o_imm,
    output logic        o_reg_write,
    output logic        o_mem_read,
    output logic        o_mem_write,
    output res_src_t    o_res_src,
    output logic        o_pc_sel,
    output logic        o_jump,
    output logic        o_branch,
    output logic        o_alu_op1_sel,
    output logic        o_alu_op2_sel,
    output funct3_t     o_funct3,
    output alu_ctrl_t   o_alu_ctrl,
    output logic        o_inv_instr
);

    word_t       instr;
    logic        slot_empty;
    instr_kind_t kind;

    rv_decode_slot u_slot (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_stall      (i_stall),
        .i_flush      (i_flush),
        .i_data       (i_data),
        .i_pc         (i_pc),
        .i_pc_p4      (i_pc_p4),
        .o_instr      (instr),
        .o_pc         (o_pc),
        .o_pc_p4      (o_pc_p4),
        .o_slot_empty (slot_empty)
    );

    rv_instr_classify u_classify (
        .i_instr  (instr),
        .o_kind   (kind),
        .o_rs1    (o_rs1),
        .o_rs2    (o_rs2),
        .o_rd     (o_rd),
        .o_funct3 (o_funct3)
    );

    rv_imm_gen u_imm (
        .i_instr (instr),
        .i_kind  (kind),
        .o_imm   (o_imm)
    );

    rv_ctrl_gen u_ctrl (
        .i_kind        (kind),
        .i_slot_empty  (slot_empty),
        .o_reg_write   (o_reg_write),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_pc_sel      (o_pc_sel),
        .o_alu_op1_sel (o_alu_op1_sel),
        .o_alu_op2_sel (o_alu_op2_sel),
        .o_inv_instr   (o_inv_instr),
        .o_res_src     (o_res_src),
        .o_alu_ctrl    (o_alu_ctrl)
    );

endmodule

//--- verif/rv_decode_sva.sv
`timescale 1ns/1ps

module rv_decode_sva
    import rv_decode_pkg::*;
(
    input logic      i_clk,
    input logic      i_reset,
    input logic      i_stall,
    input logic      i_flush,
    input word_t     i_data,
    input pc_t       i_pc,
    input pc_t       i_pc_p4,
    input reg_idx_t  o_rs1,
    input reg_idx_t  o_rs2,
    input reg_idx_t  o_rd,
    input pc_t       o_pc,
    input pc_t       o_pc_p4,
    input word_t     o_imm,
    input logic      o_reg_write,
    input logic      o_mem_read,
    input logic      o_mem_write,
    input res_src_t  o_res_src,
    input logic      o_pc_sel,
    input logic      o_jump,
    input logic      o_branch,
    input logic      o_alu_op1_sel,
    input logic      o_alu_op2_sel,
    input funct3_t   o_funct3,
    input alu_ctrl_t o_alu_ctrl,
    input logic      o_inv_instr
);

    int unsigned fail_count = 0;
    string       fail_name;
    logic [63:0] fail_exp;
    logic [63:0] fail_act;

    pc_t         exp_pc;
    pc_t         exp_pc_p4;
    logic        flush_q;
    word_t       w;
    logic [4:0]  opg;
    logic        empty;
    logic        supported_w;
    word_t       exp_imm_w;
    logic [5:0]  exp_alu_w;
    logic [8:0]  exp_flow_w;
    logic [17:0] exp_fields_w;
    logic [8:0]  act_flow;
    logic [5:0]  act_ctl;
    logic [17:0] act_fields;

    // RV32I encodings accepted by the stage
    function automatic logic supported(word_t iw);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = iw[14:12];
        f7 = iw[31:25];
        if (iw[1:0] != 2'b11)
            return 1'b0;
        case (iw[6:2])
            OPG_LOAD:     return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            OPG_STORE:    return f3 <= 3'd2;
            OPG_OP_IMM:
                if (f3 == 3'b001)
                    return f7 == 7'h00;
                else if (f3 == 3'b101)
                    return f7 == 7'h00 || f7 == 7'h20;
                else
                    return 1'b1;
            OPG_OP:       return f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
            OPG_BRANCH:   return f3 != 3'd2 && f3 != 3'd3;
            OPG_MISC_MEM: return f3 <= 3'd1;
            OPG_JALR:     return f3 == 3'd0;
            OPG_JAL, OPG_LUI, OPG_AUIPC: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic word_t exp_imm(word_t iw);
        case (iw[6:2])
            OPG_JAL:    return {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
            OPG_LUI, OPG_AUIPC: return {iw[31:12], 12'h000};
            OPG_JALR, OPG_LOAD, OPG_OP_IMM: return {{20{iw[31]}}, iw[31:20]};
            OPG_BRANCH: return {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
            OPG_STORE:  return {{20{iw[31]}}, iw[31:25], iw[11:7]};
            default:    return '0;
        endcase
    endfunction

    // {op2_sel, arith shift, alu op}
    function automatic logic [5:0] exp_alu(word_t iw);
        logic [3:0] op;
        logic       arith;
        arith = 1'b0;
        if (!(iw[6:2] inside {OPG_OP, OPG_OP_IMM, OPG_BRANCH}))
            return {OP2_IMM, 1'b0, ALU_ADD};
        if (iw[6:2] == OPG_BRANCH)
            case (iw[14:12])
                3'b000:  op = ALU_CMP_EQ;
                3'b001:  op = ALU_CMP_NEQ;
                3'b100:  op = ALU_CMP_LTS;
                3'b101:  op = ALU_CMP_NLTS;
                3'b110:  op = ALU_CMP_LTU;
                default: op = ALU_CMP_NLTU;
            endcase
        else
            case (iw[14:12])
                3'b000:  op = (iw[6:2] == OPG_OP && iw[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  op = ALU_SHL;
                3'b010:  op = ALU_CMP_LTS;
                3'b011:  op = ALU_CMP_LTU;
                3'b100:  op = ALU_XOR;
                3'b101:  op = ALU_SHR;
                3'b110:  op = ALU_OR;
                default: op = ALU_AND;
            endcase
        if (iw[14:12] == 3'b101 && iw[6:2] != OPG_BRANCH)
            arith = iw[30];
        return {iw[6:2] == OPG_OP_IMM, arith, op};
    endfunction

    // {reg_write, mem_read, mem_write, jump, branch, pc_sel, op1_sel, res_src}
    function automatic logic [8:0] exp_flow(word_t iw);
        case (iw[6:2])
            OPG_LOAD:   return {7'b1100000, RES_MEMORY};
            OPG_STORE:  return {7'b0010000, RES_ALU};
            OPG_OP, OPG_OP_IMM, OPG_LUI: return {7'b1000000, RES_ALU};
            OPG_AUIPC:  return {7'b1000001, RES_ALU};
            OPG_BRANCH: return {7'b0000100, RES_ALU};
            OPG_JAL:    return {7'b1001001, RES_PC_P4};
            OPG_JALR:   return {7'b1001010, RES_PC_P4};
            default:    return {7'b0000000, RES_ALU};
        endcase
    endfunction

    task automatic record(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
        if (fail_count == 0)
        begin
            fail_name = name;
            fail_exp  = exp_v;
            fail_act  = act_v;
        end
        fail_count++;
    endtask

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            exp_pc    <= '0;
            exp_pc_p4 <= '0;
        end
        else if (!i_stall)
        begin
            exp_pc    <= i_pc;
            exp_pc_p4 <= i_pc_p4;
        end
        flush_q <= i_flush;
    end

    // the word seen by decode is zero in a gated slot
    assign w            = (i_reset || flush_q) ? '0 : i_data;
    assign opg          = w[6:2];
    assign empty        = i_reset || i_flush || flush_q;
    assign supported_w  = supported(w);
    assign exp_imm_w    = supported_w ? exp_imm(w) : '0;
    assign exp_alu_w    = exp_alu(w);
    assign exp_flow_w   = exp_flow(w);
    assign exp_fields_w = {((supported_w && opg == OPG_LUI) ? 5'd0 : w[19:15]),
                           w[24:20], w[11:7], w[14:12]};
    assign act_flow     = {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch,
                           o_pc_sel, o_alu_op1_sel, o_res_src};
    assign act_ctl      = {o_reg_write, o_mem_read, o_mem_write, o_jump, o_branch,
                           o_inv_instr};
    assign act_fields   = {o_rs1, o_rs2, o_rd, o_funct3};

    // outputs settle well before the falling edge
    pc_pipe: assert property (@(negedge i_clk) {o_pc, o_pc_p4} == {exp_pc, exp_pc_p4})
        else begin
            record("pc_pipe", 64'({exp_pc, exp_pc_p4}), 64'({o_pc, o_pc_p4}));
            $error("pc pipeline check failed");
        end

    slot_gating: assert property (@(negedge i_clk) (i_reset || flush_q) |-> act_ctl == 6'b0)
        else begin
            record("slot_gating", 64'h0, 64'(act_ctl));
            $error("controls active in a gated slot");
        end

    inv_flag: assert property (@(negedge i_clk) o_inv_instr == (!supported_w && !empty))
        else begin
            record("inv_flag", 64'(!supported_w && !empty), 64'(o_inv_instr));
            $error("invalid flag check failed");
        end

    imm_format: assert property (@(negedge i_clk) o_imm == exp_imm_w)
        else begin
            record("imm_format", 64'(exp_imm_w), 64'(o_imm));
            $error("immediate check failed");
        end

    alu_decode: assert property (@(negedge i_clk)
        supported_w |-> {o_alu_op2_sel, o_alu_ctrl} == exp_alu_w)
        else begin
            record("alu_decode", 64'(exp_alu_w), 64'({o_alu_op2_sel, o_alu_ctrl}));
            $error("alu control check failed");
        end

    mem_flow: assert property (@(negedge i_clk) supported_w |-> act_flow == exp_flow_w)
        else begin
            record("mem_flow", 64'(exp_flow_w), 64'(act_flow));
            $error("memory or flow control check failed");
        end

    // rs1 reads as zero for lui
    reg_fields: assert property (@(negedge i_clk) act_fields == exp_fields_w)
        else begin
            record("reg_fields", 64'(exp_fields_w), 64'(act_fields));
            $error("register field or funct3 check failed");
        end

endmodule

bind rv_decode rv_decode_sva u_sva (.*);

//--- verif/tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode
    import rv_decode_pkg::*;
();

    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 3000;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_CYCLES + 4);

    localparam logic [4:0] GROUPS [10] = '{OPG_LOAD, OPG_MISC_MEM, OPG_OP_IMM, OPG_AUIPC,
                                           OPG_STORE, OPG_OP, OPG_LUI, OPG_BRANCH,
                                           OPG_JALR, OPG_JAL};

    logic        i_clk = 1'b0;
    logic        i_reset;
    logic        i_stall;
    logic        i_flush;
    word_t       i_data;
    pc_t         i_pc;
    pc_t         i_pc_p4;
    reg_idx_t    o_rs1;
    reg_idx_t    o_rs2;
    reg_idx_t    o_rd;
    pc_t         o_pc;
    pc_t         o_pc_p4;
    word_t       o_imm;
    logic        o_reg_write;
    logic        o_mem_read;
    logic        o_mem_write;
    res_src_t    o_res_src;
    logic        o_pc_sel;
    logic        o_jump;
    logic        o_branch;
    logic        o_alu_op1_sel;
    logic        o_alu_op2_sel;
    funct3_t     o_funct3;
    alu_ctrl_t   o_alu_ctrl;
    logic        o_inv_instr;

    logic [31:0] lfsr_state = 32'h54c7;
    int          cycle_count = 0;

    rv_decode i_dut (.*);

    initial
    begin
        forever #20 i_clk = ~i_clk;
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int unsigned k = 0; k < n; k++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic drive_cycle(input logic with_ctrl);
        logic [6:0] f7;
        logic [3:0] idx;
        if (rand_bits(3) == 32'd0)
            i_data = rand_bits(32);
        else
        begin
            // bias funct7 towards the legal values
            case (rand_bits(2))
                32'd0:   f7 = 7'h00;
                32'd1:   f7 = 7'h20;
                default: f7 = 7'(rand_bits(7));
            endcase
            idx    = 4'(rand_bits(4) % 32'd10);
            i_data = {f7, 18'(rand_bits(18)), GROUPS[idx], 2'b11};
        end
        i_pc    = 30'(rand_bits(30));
        i_pc_p4 = i_pc + 30'd1;
        if (with_ctrl)
        begin
            i_stall = (rand_bits(3) == 32'd0);
            i_flush = (rand_bits(4) == 32'd0);
        end
    endtask

    task automatic report_mismatch();
        $display("MISMATCH %s expected %h actual %h", i_dut.u_sva.fail_name,
                 i_dut.u_sva.fail_exp, i_dut.u_sva.fail_act);
        $display("Verification failed");
        $fatal(1, "decode check failed");
    endtask

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (i_dut.u_sva.fail_count != 0)
            report_mismatch();
        else if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        i_reset = 1'b1;
        i_stall = 1'b0;
        i_flush = 1'b0;
        i_data  = '0;
        i_pc    = '0;
        i_pc_p4 = '0;
        // random words during reset must stay gated
        repeat (RESET_CYCLES)
        begin
            @(posedge i_clk);
            #2;
            drive_cycle(1'b0);
        end
        i_reset = 1'b0;
        // ecall is not supported
        @(posedge i_clk);
        #2;
        i_data = 32'h0000_0073;
        repeat (NUM_CYCLES)
        begin
            @(posedge i_clk);
            #2;
            drive_cycle(1'b1);
        end
        @(posedge i_clk);
        @(posedge i_clk);
        #1;
        if (i_dut.u_sva.fail_count == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
            report_mismatch();
    end

endmodule

//--- sources.f
hdl/rv_decode_pkg.sv
hdl/rv_decode_slot.sv
hdl/rv_instr_classify.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_gen.sv
hdl/rv_decode.sv
verif/rv_decode_sva.sv
verif/tb_rv_decode.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timing -j 0
TOP       := tb_rv_decode
FILELIST  := sources.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+100
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard hdl/*.sv verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJ_DIR)
